//--- Makefile
VERILATOR ?= verilator
TOP ?= tbPipeCpu
DUT_TOP ?= pipeCpu
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= Everything OK

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  logic              clk,
	input  logic              rst,
	input  logic              run,
	input  mipsPkg::wordT     instrD,
	input  mipsPkg::pcT       pcPlus4D,
	input  logic              validD,
	input  mipsPkg::fwdSelT   fwdAD,
	input  mipsPkg::fwdSelT   fwdBD,
	input  mipsPkg::wordT     aluOutM,
	input  mipsPkg::wordT     resultW,
	input  mipsPkg::regAddrT  writeRegW,
	input  logic              regWriteW,
	input  logic              flushE,
	output logic              branchTaken,
	output mipsPkg::pcT       branchTarget,
	output logic              haltD,
	output mipsPkg::regAddrT  rsD,
	output mipsPkg::regAddrT  rtD,
	output logic              branchD,
	output mipsPkg::wordT     rd1E,
	output mipsPkg::wordT     rd2E,
	output mipsPkg::wordT     immE,
	output mipsPkg::regAddrT  rsE,
	output mipsPkg::regAddrT  rtE,
	output mipsPkg::regAddrT  rdE,
	output mipsPkg::aluCtlT   aluCtlE,
	output logic              aluSrcE,
	output logic              regDstE,
	output logic              regWriteE,
	output logic              memToRegE,
	output logic              memWriteE,
	output logic              haltE,
	output logic              validE
);

	// 32 registers, r0 never written
	mipsPkg::wordT regFile [32];

	logic [5:0] opD;
	logic [5:0] functD;
	mipsPkg::regAddrT rdD;
	mipsPkg::wordT immD;
	mipsPkg::wordT rd1D;
	mipsPkg::wordT rd2D;
	mipsPkg::wordT cmpA;
	mipsPkg::wordT cmpB;

	mipsPkg::aluCtlT aluCtlD;
	logic aluSrcD;
	logic regDstD;
	logic regWriteD;
	logic memToRegD;
	logic memWriteD;

	// Instruction fields
	assign opD = instrD[31:26];
	assign functD = instrD[5:0];
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign immD = {{16{instrD[15]}}, instrD[15:0]};

	// --------------------
	// Control decode
	// --------------------

	always_comb
	begin
		aluCtlD = mipsPkg::aluAdd;
		aluSrcD = 1'b0;
		regDstD = 1'b0;
		regWriteD = 1'b0;
		memToRegD = 1'b0;
		memWriteD = 1'b0;
		branchD = 1'b0;
		haltD = 1'b0;
		// Bubbles decode to nothing
		if (validD)
		begin
			case (opD)
				mipsPkg::opRType:
				begin
					regDstD = 1'b1;
					regWriteD = 1'b1;
					case (functD)
						mipsPkg::fnAdd: aluCtlD = mipsPkg::aluAdd;
						mipsPkg::fnSub: aluCtlD = mipsPkg::aluSub;
						mipsPkg::fnAnd: aluCtlD = mipsPkg::aluAnd;
						mipsPkg::fnOr: aluCtlD = mipsPkg::aluOr;
						mipsPkg::fnSlt: aluCtlD = mipsPkg::aluSlt;
						// Unknown funct retires silently
						default: regWriteD = 1'b0;
					endcase
				end
				mipsPkg::opAddi:
				begin
					aluSrcD = 1'b1;
					regWriteD = 1'b1;
				end
				mipsPkg::opLw:
				begin
					aluSrcD = 1'b1;
					regWriteD = 1'b1;
					memToRegD = 1'b1;
				end
				mipsPkg::opSw:
				begin
					aluSrcD = 1'b1;
					memWriteD = 1'b1;
				end
				mipsPkg::opBeq: branchD = 1'b1;
				mipsPkg::opHalt: haltD = 1'b1;
				default: ;
			endcase
		end
	end

	// --------------------
	// Register file
	// --------------------

	// Written in the falling half so decode sees it the same cycle
	always_ff @(negedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regFile[i] <= '0;
		end
		else if (regWriteW && writeRegW != '0)
			regFile[writeRegW] <= resultW;
	end

	assign rd1D = regFile[rsD];
	assign rd2D = regFile[rtD];

	// Branch compare, memory stage result forwarded
	assign cmpA = (fwdAD == mipsPkg::fwdMem) ? aluOutM : rd1D;
	assign cmpB = (fwdBD == mipsPkg::fwdMem) ? aluOutM : rd2D;
	assign branchTaken = branchD && (cmpA == cmpB);
	// Word offset, wraps inside the small PC
	assign branchTarget = pcPlus4D + {immD[5:0], 2'b00};

	// --------------------
	// ID/EX register
	// --------------------

	always_ff @(posedge clk)
	begin
		if (rst || (run && flushE))
		begin
			validE <= 1'b0;
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memWriteE <= 1'b0;
			haltE <= 1'b0;
		end
		else if (run)
		begin
			validE <= validD;
			regWriteE <= regWriteD;
			memToRegE <= memToRegD;
			memWriteE <= memWriteD;
			haltE <= haltD;
		end
	end

	// Operands and selects
	always_ff @(posedge clk)
	begin
		if (run)
		begin
			rd1E <= rd1D;
			rd2E <= rd2D;
			immE <= immD;
			rsE <= rsD;
			rtE <= rtD;
			rdE <= rdD;
			aluCtlE <= aluCtlD;
			aluSrcE <= aluSrcD;
			regDstE <= regDstD;
		end
	end

	// Write-back qualification happens in the memory stage
	assert property (@(negedge clk) disable iff (rst) regWriteW |-> writeRegW != '0);

endmodule

`default_nettype wire

//--- executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input  logic              clk,
	input  logic              rst,
	input  logic              run,
	input  mipsPkg::wordT     rd1E,
	input  mipsPkg::wordT     rd2E,
	input  mipsPkg::wordT     immE,
	input  mipsPkg::regAddrT  rtE,
	input  mipsPkg::regAddrT  rdE,
	input  mipsPkg::aluCtlT   aluCtlE,
	input  logic              aluSrcE,
	input  logic              regDstE,
	input  logic              regWriteE,
	input  logic              memToRegE,
	input  logic              memWriteE,
	input  logic              haltE,
	input  logic              validE,
	input  mipsPkg::fwdSelT   fwdAE,
	input  mipsPkg::fwdSelT   fwdBE,
	input  mipsPkg::wordT     resultW,
	output mipsPkg::regAddrT  writeRegE,
	output mipsPkg::wordT     aluOutM,
	output mipsPkg::wordT     writeDataM,
	output mipsPkg::regAddrT  writeRegM,
	output logic              regWriteM,
	output logic              memToRegM,
	output logic              memWriteM,
	output logic              haltM,
	output logic              validM
);

	mipsPkg::wordT srcAE;
	mipsPkg::wordT writeDataE;
	mipsPkg::wordT srcBE;
	mipsPkg::wordT aluOutE;

	// Forwarding muxes
	always_comb
	begin
		case (fwdAE)
			mipsPkg::fwdMem: srcAE = aluOutM;
			mipsPkg::fwdWb: srcAE = resultW;
			default: srcAE = rd1E;
		endcase
		case (fwdBE)
			mipsPkg::fwdMem: writeDataE = aluOutM;
			mipsPkg::fwdWb: writeDataE = resultW;
			default: writeDataE = rd2E;
		endcase
	end

	// Immediate for addi, lw, sw
	assign srcBE = aluSrcE ? immE : writeDataE;
	// rd for R-type, rt otherwise
	assign writeRegE = regDstE ? rdE : rtE;

	// --------------------
	// ALU
	// --------------------

	always_comb
	begin
		case (aluCtlE)
			mipsPkg::aluSub: aluOutE = srcAE - srcBE;
			mipsPkg::aluAnd: aluOutE = srcAE & srcBE;
			mipsPkg::aluOr: aluOutE = srcAE | srcBE;
			// Signed less-than
			mipsPkg::aluSlt: aluOutE = {31'b0, $signed(srcAE) < $signed(srcBE)};
			default: aluOutE = srcAE + srcBE;
		endcase
	end

	// --------------------
	// EX/MEM register
	// --------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			validM <= 1'b0;
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
			haltM <= 1'b0;
		end
		else if (run)
		begin
			validM <= validE;
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
			haltM <= haltE;
		end
	end

	always_ff @(posedge clk)
	begin
		if (run)
		begin
			aluOutM <= aluOutE;
			writeDataM <= writeDataE;
			writeRegM <= writeRegE;
		end
	end

endmodule

`default_nettype wire

//--- fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
	input  logic           clk,
	input  logic           rst,
	input  logic           run,
	input  logic           stallF,
	input  logic           stallD,
	input  logic           branchTaken,
	input  mipsPkg::pcT    branchTarget,
	input  logic           haltD,
	input  logic           imemWe,
	input  mipsPkg::pcT    imemAddr,
	input  mipsPkg::wordT  imemData,
	output mipsPkg::wordT  instrD,
	output mipsPkg::pcT    pcPlus4D,
	output logic           validD
);

	// Instruction memory, word indexed
	mipsPkg::wordT imem [mipsPkg::imemWords];

	mipsPkg::pcT pcF;
	mipsPkg::pcT pcPlus4F;
	mipsPkg::wordT instrF;
	// Halt already passed decode
	logic haltSeen;
	logic fetchStop;
	// IF/ID gets a bubble
	logic bubbleD;

	// Loader port, only while stopped
	always_ff @(posedge clk)
	begin
		if (imemWe && !run)
			imem[imemAddr[7:2]] <= imemData;
	end

	assign instrF = imem[pcF[7:2]];
	assign pcPlus4F = pcF + mipsPkg::pcT'(4);

	// Halt in decode or behind us freezes the PC
	assign fetchStop = haltD || haltSeen;
	assign bubbleD = branchTaken || fetchStop;

	// --------------------
	// Program counter
	// --------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			pcF <= '0;
		else if (run && !stallF && !fetchStop)
			pcF <= branchTaken ? branchTarget : pcPlus4F;
	end

	// Sticky once halt leaves decode
	always_ff @(posedge clk)
	begin
		if (rst)
			haltSeen <= 1'b0;
		else if (run && haltD && !stallD)
			haltSeen <= 1'b1;
	end

	// --------------------
	// IF/ID register
	// --------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			validD <= 1'b0;
		else if (run && !stallD)
			validD <= !bubbleD;
	end

	// Zero word on a bubble keeps hazard compares quiet
	always_ff @(posedge clk)
	begin
		if (run && !stallD)
		begin
			instrD <= bubbleD ? '0 : instrF;
			pcPlus4D <= pcPlus4F;
		end
	end

	// Loading a running program would corrupt fetch
	assert property (@(posedge clk) disable iff (rst) imemWe |-> !run);

endmodule

`default_nettype wire

//--- files.f
mipsPkg.sv
fetchStage.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memStage.sv
pipeCpu.sv
tbPipeCpu.sv

//--- hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  mipsPkg::regAddrT  rsD,
	input  mipsPkg::regAddrT  rtD,
	input  logic              branchD,
	input  mipsPkg::regAddrT  rsE,
	input  mipsPkg::regAddrT  rtE,
	input  mipsPkg::regAddrT  writeRegE,
	input  logic              regWriteE,
	input  logic              memToRegE,
	input  mipsPkg::regAddrT  writeRegM,
	input  logic              regWriteM,
	input  logic              memToRegM,
	input  mipsPkg::regAddrT  writeRegW,
	input  logic              regWriteW,
	output logic              stallF,
	output logic              stallD,
	output logic              flushE,
	output mipsPkg::fwdSelT   fwdAD,
	output mipsPkg::fwdSelT   fwdBD,
	output mipsPkg::fwdSelT   fwdAE,
	output mipsPkg::fwdSelT   fwdBE
);

	logic lwStall;
	logic branchStall;

	always_comb
	begin
		// --------------------
		// Execute forwarding
		// --------------------

		// Memory stage wins as the younger result
		fwdAE = mipsPkg::fwdNone;
		if (rsE != '0 && regWriteM && writeRegM == rsE)
			fwdAE = mipsPkg::fwdMem;
		else if (rsE != '0 && regWriteW && writeRegW == rsE)
			fwdAE = mipsPkg::fwdWb;

		fwdBE = mipsPkg::fwdNone;
		if (rtE != '0 && regWriteM && writeRegM == rtE)
			fwdBE = mipsPkg::fwdMem;
		else if (rtE != '0 && regWriteW && writeRegW == rtE)
			fwdBE = mipsPkg::fwdWb;

		// Decode compare sees write-back through the register file
		fwdAD = (rsD != '0 && regWriteM && writeRegM == rsD)
			? mipsPkg::fwdMem : mipsPkg::fwdNone;
		fwdBD = (rtD != '0 && regWriteM && writeRegM == rtD)
			? mipsPkg::fwdMem : mipsPkg::fwdNone;

		// --------------------
		// Stalls
		// --------------------

		// Load in execute feeding decode
		lwStall = memToRegE && (rtE == rsD || rtE == rtD);

		// Branch operand still in execute or a load in memory
		branchStall = branchD
			&& ((regWriteE && (writeRegE == rsD || writeRegE == rtD))
			|| (memToRegM && (writeRegM == rsD || writeRegM == rtD)));

		stallD = lwStall || branchStall;
		stallF = stallD;
		// Bubble into execute while decode holds
		flushE = stallD;
	end

endmodule

`default_nettype wire

//--- memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage (
	input  logic              clk,
	input  logic              rst,
	input  logic              run,
	input  mipsPkg::wordT     aluOutM,
	input  mipsPkg::wordT     writeDataM,
	input  mipsPkg::regAddrT  writeRegM,
	input  logic              regWriteM,
	input  logic              memToRegM,
	input  logic              memWriteM,
	input  logic              haltM,
	input  logic              validM,
	output mipsPkg::wordT     resultW,
	output mipsPkg::regAddrT  writeRegW,
	output logic              regWriteW,
	output logic              wbValid,
	output mipsPkg::regAddrT  wbReg,
	output mipsPkg::wordT     wbData,
	output logic              halted
);

	// Data memory, word indexed
	mipsPkg::wordT dmem [mipsPkg::dmemWords];

	mipsPkg::wordT readDataM;
	// Real write to a nonzero register
	logic wbWriteM;

	assign readDataM = dmem[aluOutM[7:2]];
	assign wbWriteM = validM && regWriteM && (writeRegM != '0);

	// Synchronous write, cleared on reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < mipsPkg::dmemWords; i++)
				dmem[i] <= '0;
		end
		else if (run && validM && memWriteM)
			dmem[aluOutM[7:2]] <= writeDataM;
	end

	// --------------------
	// MEM/WB register
	// --------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regWriteW <= 1'b0;
			wbValid <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			// One pulse per retirement, none while frozen
			wbValid <= run && wbWriteM;
			if (run)
				regWriteW <= wbWriteM;
			// Sticky until reset
			if (run && validM && haltM)
				halted <= 1'b1;
		end
	end

	// Result select ahead of the register
	always_ff @(posedge clk)
	begin
		if (run)
		begin
			resultW <= memToRegM ? readDataM : aluOutM;
			writeRegW <= writeRegM;
		end
	end

	// Observable write-back port
	assign wbReg = writeRegW;
	assign wbData = resultW;

endmodule

`default_nettype wire

//--- mipsPkg.sv
`default_nettype none

package mipsPkg;

	// --------------------
	// Word and field types
	// --------------------

	// Data or instruction word
	typedef logic [31:0] wordT;
	// Register number
	typedef logic [4:0] regAddrT;
	// Byte address into instruction memory
	typedef logic [7:0] pcT;
	// ALU operation select
	typedef logic [2:0] aluCtlT;
	// Forward source select
	typedef logic [1:0] fwdSelT;

	// --------------------
	// Opcodes and functs
	// --------------------

	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;
	// All ones, stops fetch
	localparam logic [5:0] opHalt = 6'h3f;

	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	// ALU control, classic MIPS encoding
	localparam aluCtlT aluAnd = 3'd0;
	localparam aluCtlT aluOr = 3'd1;
	localparam aluCtlT aluAdd = 3'd2;
	localparam aluCtlT aluSub = 3'd6;
	localparam aluCtlT aluSlt = 3'd7;

	// --------------------
	// Sizes and selects
	// --------------------

	localparam int imemWords = 64;
	// Indexed by ALU result bits 7:2
	localparam int dmemWords = 64;

	localparam fwdSelT fwdNone = 2'd0;
	localparam fwdSelT fwdMem = 2'd1;
	localparam fwdSelT fwdWb = 2'd2;

endpackage

`default_nettype wire

//--- pipeCpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCpu (
	input  logic              clk,
	input  logic              rst,
	input  logic              run,
	input  logic              imemWe,
	input  mipsPkg::pcT       imemAddr,
	input  mipsPkg::wordT     imemData,
	output logic              wbValid,
	output mipsPkg::regAddrT  wbReg,
	output mipsPkg::wordT     wbData,
	output logic              halted
);

	// Fetch to decode
	mipsPkg::wordT instrD;
	mipsPkg::pcT pcPlus4D;
	logic validD;
	logic branchTaken;
	mipsPkg::pcT branchTarget;
	logic haltD;

	// Hazard controls
	logic stallF;
	logic stallD;
	logic flushE;
	mipsPkg::fwdSelT fwdAD;
	mipsPkg::fwdSelT fwdBD;
	mipsPkg::fwdSelT fwdAE;
	mipsPkg::fwdSelT fwdBE;

	// Decode side
	mipsPkg::regAddrT rsD;
	mipsPkg::regAddrT rtD;
	logic branchD;

	// ID/EX
	mipsPkg::wordT rd1E;
	mipsPkg::wordT rd2E;
	mipsPkg::wordT immE;
	mipsPkg::regAddrT rsE;
	mipsPkg::regAddrT rtE;
	mipsPkg::regAddrT rdE;
	mipsPkg::aluCtlT aluCtlE;
	logic aluSrcE;
	logic regDstE;
	logic regWriteE;
	logic memToRegE;
	logic memWriteE;
	logic haltE;
	logic validE;
	mipsPkg::regAddrT writeRegE;

	// EX/MEM
	mipsPkg::wordT aluOutM;
	mipsPkg::wordT writeDataM;
	mipsPkg::regAddrT writeRegM;
	logic regWriteM;
	logic memToRegM;
	logic memWriteM;
	logic haltM;
	logic validM;

	// MEM/WB
	mipsPkg::wordT resultW;
	mipsPkg::regAddrT writeRegW;
	logic regWriteW;

	fetchStage i_fetch (
		.clk(clk),
		.rst(rst),
		.run(run),
		.stallF(stallF),
		.stallD(stallD),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.haltD(haltD),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.instrD(instrD),
		.pcPlus4D(pcPlus4D),
		.validD(validD)
	);

	decodeStage i_decode (
		.clk(clk),
		.rst(rst),
		.run(run),
		.instrD(instrD),
		.pcPlus4D(pcPlus4D),
		.validD(validD),
		.fwdAD(fwdAD),
		.fwdBD(fwdBD),
		.aluOutM(aluOutM),
		.resultW(resultW),
		.writeRegW(writeRegW),
		.regWriteW(regWriteW),
		.flushE(flushE),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.haltD(haltD),
		.rsD(rsD),
		.rtD(rtD),
		.branchD(branchD),
		.rd1E(rd1E),
		.rd2E(rd2E),
		.immE(immE),
		.rsE(rsE),
		.rtE(rtE),
		.rdE(rdE),
		.aluCtlE(aluCtlE),
		.aluSrcE(aluSrcE),
		.regDstE(regDstE),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.memWriteE(memWriteE),
		.haltE(haltE),
		.validE(validE)
	);

	hazardUnit i_hazard (
		.rsD(rsD),
		.rtD(rtD),
		.branchD(branchD),
		.rsE(rsE),
		.rtE(rtE),
		.writeRegE(writeRegE),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.writeRegM(writeRegM),
		.regWriteM(regWriteM),
		.memToRegM(memToRegM),
		.writeRegW(writeRegW),
		.regWriteW(regWriteW),
		.stallF(stallF),
		.stallD(stallD),
		.flushE(flushE),
		.fwdAD(fwdAD),
		.fwdBD(fwdBD),
		.fwdAE(fwdAE),
		.fwdBE(fwdBE)
	);

	executeStage i_execute (
		.clk(clk),
		.rst(rst),
		.run(run),
		.rd1E(rd1E),
		.rd2E(rd2E),
		.immE(immE),
		.rtE(rtE),
		.rdE(rdE),
		.aluCtlE(aluCtlE),
		.aluSrcE(aluSrcE),
		.regDstE(regDstE),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.memWriteE(memWriteE),
		.haltE(haltE),
		.validE(validE),
		.fwdAE(fwdAE),
		.fwdBE(fwdBE),
		.resultW(resultW),
		.writeRegE(writeRegE),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.writeRegM(writeRegM),
		.regWriteM(regWriteM),
		.memToRegM(memToRegM),
		.memWriteM(memWriteM),
		.haltM(haltM),
		.validM(validM)
	);

	memStage i_mem (
		.clk(clk),
		.rst(rst),
		.run(run),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.writeRegM(writeRegM),
		.regWriteM(regWriteM),
		.memToRegM(memToRegM),
		.memWriteM(memWriteM),
		.haltM(haltM),
		.validM(validM),
		.resultW(resultW),
		.writeRegW(writeRegW),
		.regWriteW(regWriteW),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(halted)
	);

endmodule

`default_nettype wire

//--- tbPipeCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbPipeCpu;

	// Program length, last slot is halt
	localparam int progLen = 40;
	localparam int runLimit = 2000;
	localparam int quietCycles = 20;

	logic clk;
	logic rst;
	logic run;
	logic imemWe;
	mipsPkg::pcT imemAddr;
	mipsPkg::wordT imemData;
	logic wbValid;
	mipsPkg::regAddrT wbReg;
	mipsPkg::wordT wbData;
	logic halted;

	mipsPkg::wordT prog [progLen];
	// Expected retirements in program order
	mipsPkg::regAddrT expReg [$];
	mipsPkg::wordT expData [$];
	int errors;
	int checks;

	pipeCpu i_dut (
		.clk(clk),
		.rst(rst),
		.run(run),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(halted)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// --------------------
	// Checks
	// --------------------

	task automatic checkReg(input string name, input mipsPkg::regAddrT got,
		input mipsPkg::regAddrT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkWord(input string name, input mipsPkg::wordT got,
		input mipsPkg::wordT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic noteFailure(input string msg);
		errors++;
		$display("ERROR: %s at %0t", msg, $time);
	endtask

	// --------------------
	// Program generator
	// --------------------

	function automatic mipsPkg::wordT encodeRType(input logic [5:0] fn,
		input mipsPkg::regAddrT rd, input mipsPkg::regAddrT rs, input mipsPkg::regAddrT rt);
		return {mipsPkg::opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mipsPkg::wordT encodeIType(input logic [5:0] op,
		input mipsPkg::regAddrT rs, input mipsPkg::regAddrT rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Only r1..r7, keeps dependences dense
	function automatic mipsPkg::regAddrT pickReg();
		return mipsPkg::regAddrT'(1 + $urandom % 7);
	endfunction

	task automatic buildProgram();
		int i;
		int kind;
		int sel;
		int maxSkip;
		logic [5:0] fn;
		mipsPkg::regAddrT rs;
		mipsPkg::regAddrT rt;
		for (i = 0; i < progLen - 1; i++)
		begin
			kind = int'($urandom % 100);
			// Branch target must not pass the halt
			maxSkip = progLen - 2 - i;
			if (kind < 40)
			begin
				sel = int'($urandom % 5);
				case (sel)
					0: fn = mipsPkg::fnAdd;
					1: fn = mipsPkg::fnSub;
					2: fn = mipsPkg::fnAnd;
					3: fn = mipsPkg::fnOr;
					default: fn = mipsPkg::fnSlt;
				endcase
				prog[i] = encodeRType(fn, pickReg(), pickReg(), pickReg());
			end
			else if (kind < 60 || (kind >= 86 && maxSkip < 1))
				prog[i] = encodeIType(mipsPkg::opAddi, pickReg(), pickReg(), 16'($urandom));
			// Base r0, few word slots so stores and loads meet
			else if (kind < 73)
				prog[i] = encodeIType(mipsPkg::opLw, 5'd0, pickReg(),
					16'(($urandom % 8) * 4));
			else if (kind < 86)
				prog[i] = encodeIType(mipsPkg::opSw, 5'd0, pickReg(),
					16'(($urandom % 8) * 4));
			else
			begin
				rs = pickReg();
				// Same register a third of the time, always taken
				rt = ($urandom % 3 == 0) ? rs : pickReg();
				sel = 1 + int'($urandom % 3);
				if (sel > maxSkip)
					sel = maxSkip;
				prog[i] = encodeIType(mipsPkg::opBeq, rs, rt, 16'(sel));
			end
		end
		prog[progLen - 1] = {mipsPkg::opHalt, 26'd0};
	endtask

	// --------------------
	// Reference model
	// --------------------

	// Instruction level, no delay slot
	task automatic runModel();
		mipsPkg::wordT regs [32];
		mipsPkg::wordT dmem [mipsPkg::dmemWords];
		mipsPkg::wordT instr;
		mipsPkg::wordT a;
		mipsPkg::wordT b;
		mipsPkg::wordT imm;
		mipsPkg::wordT addr;
		mipsPkg::wordT res;
		mipsPkg::regAddrT dest;
		int pc;
		int steps;
		logic writes;
		logic done;
		foreach (regs[k])
			regs[k] = '0;
		foreach (dmem[k])
			dmem[k] = '0;
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done && pc < progLen && steps < 200)
		begin
			instr = prog[pc];
			a = regs[instr[25:21]];
			b = regs[instr[20:16]];
			imm = {{16{instr[15]}}, instr[15:0]};
			addr = a + imm;
			res = '0;
			dest = instr[20:16];
			writes = 1'b0;
			pc++;
			steps++;
			case (instr[31:26])
				mipsPkg::opRType:
				begin
					dest = instr[15:11];
					writes = 1'b1;
					case (instr[5:0])
						mipsPkg::fnAdd: res = a + b;
						mipsPkg::fnSub: res = a - b;
						mipsPkg::fnAnd: res = a & b;
						mipsPkg::fnOr: res = a | b;
						mipsPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				mipsPkg::opAddi:
				begin
					res = addr;
					writes = 1'b1;
				end
				mipsPkg::opLw:
				begin
					res = dmem[addr[7:2]];
					writes = 1'b1;
				end
				mipsPkg::opSw: dmem[addr[7:2]] = b;
				mipsPkg::opBeq:
				begin
					if (a == b)
						pc = pc + int'($signed(instr[15:0]));
				end
				mipsPkg::opHalt: done = 1'b1;
				default: ;
			endcase
			if (writes && dest != '0)
			begin
				regs[dest] = res;
				expReg.push_back(dest);
				expData.push_back(res);
			end
		end
	endtask

	// Loader port, run stays low
	task automatic loadProgram();
		int i;
		for (i = 0; i < progLen; i++)
		begin
			@(negedge clk);
			imemWe = 1'b1;
			imemAddr = mipsPkg::pcT'(i * 4);
			imemData = prog[i];
		end
		@(negedge clk);
		imemWe = 1'b0;
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial
	begin
		int wbIdx;
		int cycles;
		int pauseAt;
		int pauseLen;
		int pauseLeft;
		logic paused;
		clk = 1'b0;
		rst = 1'b1;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		errors = 0;
		checks = 0;
		void'($urandom(23));
		buildProgram();
		runModel();
		// Freeze somewhere in the middle of the retirements
		pauseAt = expReg.size() / 3 + int'($urandom % (expReg.size() / 3 + 1));
		pauseLen = 1 + int'($urandom % 12);
		repeat (10) @(negedge clk);
		rst = 1'b0;
		// Idle machine after reset
		repeat (4)
		begin
			@(negedge clk);
			if (wbValid || halted)
				noteFailure("wbValid or halted high before the program runs");
		end
		loadProgram();
		run = 1'b1;
		wbIdx = 0;
		cycles = 0;
		pauseLeft = 0;
		paused = 1'b0;
		while (!halted && cycles < runLimit)
		begin
			@(negedge clk);
			cycles++;
			if (wbValid)
			begin
				if (wbIdx < expReg.size())
				begin
					checkReg("wbReg", wbReg, expReg[wbIdx]);
					checkWord("wbData", wbData, expData[wbIdx]);
				end
				else
					noteFailure("write-back beyond the end of the expected sequence");
				wbIdx++;
			end
			if (!paused && wbIdx >= pauseAt)
			begin
				paused = 1'b1;
				pauseLeft = pauseLen;
			end
			run = (pauseLeft == 0);
			if (pauseLeft > 0)
				pauseLeft--;
		end
		run = 1'b1;
		if (!halted)
			noteFailure("timeout, halted never rose");
		else if (wbIdx != expReg.size())
			noteFailure("halted rose with write-backs still missing");
		// Nothing may retire after halt
		repeat (quietCycles)
		begin
			@(negedge clk);
			if (wbValid)
				noteFailure("write-back after halted");
			if (!halted)
				noteFailure("halted dropped before reset");
		end
		$display("Checks %0d, write-backs %0d of %0d, pause of %0d cycles, errors %0d",
			checks, wbIdx, expReg.size(), pauseLen, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
